/* sim.f */
hdl/erx_pkg.sv
hdl/erx_cfg.sv
hdl/erx_remap.sv
hdl/erx_check.sv
hdl/erx_dispatch.sv
hdl/erx_top.sv
verification/erx_assertions.sv
verification/erx_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module erx_tb -f sim.f -o erx_sim
./obj_dir/erx_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   exit 1
fi

/* verification/erx_tb.sv */
`timescale 1ns/1ns
module erx_tb;

   localparam int RFAW       = 6;
   localparam int FIFO_DEPTH = 8;
   localparam int ROUNDS     = 6;
   localparam int ROUND_TXN  = 30;
   localparam int STALL_TXN  = 5;   // one past the output credits
   localparam longint WATCHDOG_CYCLES = (ROUNDS * ROUND_TXN + 2 * STALL_TXN) * 1100 + 4000;
   localparam logic [RFAW-1:0] CFG_WORD    = RFAW'(erx_pkg::erx_cfg);
   localparam logic [RFAW-1:0] GPIO_WORD   = RFAW'(erx_pkg::erx_gpio);
   localparam logic [RFAW-1:0] STATUS_WORD = RFAW'(erx_pkg::erx_status);
   localparam logic [RFAW-1:0] OFFSET_WORD = RFAW'(erx_pkg::erx_offset);

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic        mi_en = 1'b0;
   logic        mi_we = 1'b0;
   logic [14:0] mi_addr = '0;
   logic [31:0] mi_din = '0;
   logic [31:0] mi_dout;
   logic [8:0]  gpio_datain = '0;
   logic        mmu_enable;
   logic        rx_valid = 1'b0;
   logic        rx_write = 1'b0;
   logic [31:0] rx_addr = '0;
   logic [31:0] rx_data = '0;
   logic        rx_credit;
   logic        out_valid;
   logic [31:0] out_addr;
   logic [31:0] out_data;
   logic        out_credit = 1'b0;

   // reference model state
   logic [64:0] send_q[$];            // {write, addr, data} waiting for a credit
   logic [63:0] exp_q[$];             // {addr, data} due at the output
   logic [31:0] sh_cfg = '0;          // shadow of erx_cfg
   logic [31:0] sh_base = '0;
   logic [2:0]  exp_sticky = '0;
   logic [8:0]  gpio_last;
   logic        hold_credits = 1'b0;  // receiver withholds credits
   int          rx_credits_avail = FIFO_DEPTH;
   int          dut_credits = erx_pkg::OUT_CREDITS;
   int          sent_cnt = 0;
   int          credit_cnt = 0;

   erx_top #(.RFAW(RFAW), .FIFO_DEPTH(FIFO_DEPTH)) erx_top_i (.*);

   always #10 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   task automatic reg_write(input logic [RFAW-1:0] word, input logic [31:0] data);
      @(negedge clk);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = 15'({word, 2'b00});   // byte address
      mi_din  = data;
      @(negedge clk);
      mi_en = 1'b0;
      mi_we = 1'b0;
      if (word == CFG_WORD) sh_cfg = data;
      if (word == OFFSET_WORD) sh_base = data;
   endtask

   // new gpio value goes out with each request
   task automatic reg_read(input logic [RFAW-1:0] word, output logic [31:0] data);
      @(negedge clk);
      gpio_last   = gpio_datain;
      gpio_datain = 9'($urandom);
      mi_en       = 1'b1;
      mi_addr     = 15'({word, 2'b00});
      @(negedge clk);
      data  = mi_dout;
      mi_en = 1'b0;
      @(negedge clk);
      check_value("idle readback", 32'd0, mi_dout);   // zero after a non-read
   endtask

   function automatic logic [31:0] remap_model(input logic [31:0] addr);
      logic [31:0] result;
      result = addr;
      if (sh_cfg[3:2] == 2'b01) begin
         for (int i = 0; i < 12; i++) begin
            if (sh_cfg[4 + i]) result[20 + i] = sh_cfg[16 + i];   // pattern bit wins
         end
      end else if (sh_cfg[3:2] == 2'b10) begin
         result = addr + sh_base;
      end
      return result;
   endfunction

   task automatic queue_txn(input logic write, input logic [31:0] addr, input logic [31:0] data);
      send_q.push_back({write, addr, data});
      if (!write) begin
         exp_sticky[erx_pkg::status_read_bit] = 1'b1;
      end else if (addr[1:0] != 2'b00) begin
         exp_sticky[erx_pkg::status_misaligned_bit] = 1'b1;
      end else begin
         exp_q.push_back({remap_model(addr), data});
      end
   endtask

   // all sent, all out, all credits home on both ports
   task automatic wait_drain();
      @(negedge clk);
      while (send_q.size() != 0 || exp_q.size() != 0 || rx_credits_avail != FIFO_DEPTH
             || dut_credits != erx_pkg::OUT_CREDITS) @(negedge clk);
      repeat (2) @(negedge clk);   // sticky bits settle
   endtask

   task automatic stall_test(input string name, input logic [1:0] timer, input logic expire);
      logic [31:0] data;
      reg_write(CFG_WORD, {2'b00, timer, 28'd0});   // remap none
      hold_credits = 1'b1;
      for (int i = 0; i < STALL_TXN; i++) begin
         queue_txn(1'b1, $urandom & ~32'h3, $urandom);
      end
      while (exp_q.size() > STALL_TXN - erx_pkg::OUT_CREDITS) @(negedge clk);
      repeat (200) @(negedge clk);   // one entry stuck, no credits
      hold_credits = 1'b0;
      wait_drain();
      if (expire) exp_sticky[erx_pkg::status_timeout_bit] = 1'b1;
      reg_read(STATUS_WORD, data);
      check_value(name, 32'(exp_sticky), 32'(data[2:0]));
   endtask

   //####################################################################
   // sender, receiver and output monitor
   //####################################################################
   always @(negedge clk) begin : link_driver
      logic [63:0] exp;
      logic [64:0] txn;
      if (!reset) begin
         if (rx_credit) begin
            rx_credits_avail++;
            credit_cnt++;
         end
         if (out_valid) begin
            if (dut_credits == 0) fail_run("out_valid asserted with no output credit granted");
            if (exp_q.size() == 0) fail_run("output transaction that the model did not expect");
            dut_credits--;
            exp = exp_q.pop_front();
            check_value("remap address", exp[63:32], out_addr);
            check_value("forwarded data", exp[31:0], out_data);
         end
         out_credit = 1'b0;   // random return delay
         if (!hold_credits && dut_credits < erx_pkg::OUT_CREDITS && $urandom_range(2) == 0) begin
            out_credit = 1'b1;
            dut_credits++;
         end
         rx_valid = 1'b0;
         if (send_q.size() != 0 && rx_credits_avail != 0 && $urandom_range(3) != 0) begin
            txn = send_q.pop_front();
            {rx_write, rx_addr, rx_data} = txn;
            rx_valid = 1'b1;
            rx_credits_avail--;
            sent_cnt++;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * 20);
      fail_run("watchdog expired before the tests finished");
   end

   //####################################################################
   // test sequence
   //####################################################################
   initial begin
      logic [31:0] data;
      logic [31:0] rd;
      logic [31:0] addr;
      int          kind;
      void'($urandom(32'h99d9f43b));
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < 16; i++) begin
         data = $urandom;
         if ($urandom_range(1) == 0) begin
            reg_write(CFG_WORD, data);
            reg_read(CFG_WORD, rd);
            check_value("cfg readback", data, rd);
            check_value("mmu enable", 32'(data[1]), 32'(mmu_enable));
         end else begin
            reg_write(OFFSET_WORD, data);
            reg_read(OFFSET_WORD, rd);
            check_value("offset readback", data, rd);
         end
         reg_read(GPIO_WORD, rd);
         check_value("gpio readback", {23'd0, gpio_last}, rd);
         reg_read(RFAW'(4 + $urandom_range(59)), rd);   // unmapped words
         check_value("unused readback", 32'd0, rd);
      end
      for (int r = 0; r < ROUNDS; r++) begin
         data = $urandom;
         data[29:28] = 2'b00;   // timer off during traffic
         reg_write(CFG_WORD, data);
         reg_write(OFFSET_WORD, $urandom);
         for (int t = 0; t < ROUND_TXN; t++) begin
            kind = $urandom_range(9);
            addr = $urandom;
            if (kind < 7) addr[1:0] = 2'b00;   // good write
            else if (kind < 9 && addr[1:0] == 2'b00) addr[0] = 1'b1;
            queue_txn(kind != 9, addr, $urandom);
         end
         wait_drain();
      end
      reg_read(STATUS_WORD, rd);
      check_value("filter sticky", 32'(exp_sticky), 32'(rd[2:0]));
      stall_test("stall timer off", erx_pkg::timer_off, 1'b0);
      stall_test("stall timer 64", erx_pkg::timer_64, 1'b1);
      check_value("rx credit count", 32'(sent_cnt), 32'(credit_cnt));
      $display("test passed");
      $finish;
   end

endmodule

/* verification/erx_assertions.sv */
`timescale 1ns/1ns
module erx_assertions (
   input logic clk,
   input logic reset,
   input logic out_valid,
   input logic out_credit,
   input logic rx_credit
);

   int granted;   // downstream credits in hand, counted from the port pulses

   always_ff @(posedge clk) begin
      if (reset) begin
         granted <= erx_pkg::OUT_CREDITS;
      end else begin
         granted <= granted + int'(out_credit) - int'(out_valid);   // return in, send out
      end
   end

   // no send without a downstream credit
   out_needs_credit: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> granted > 0) else $error("out_valid high with zero output credits");

   // both ports quiet straight out of reset
   quiet_after_reset: assert property (@(posedge clk)
      reset |=> !rx_credit && !out_valid) else $error("rx_credit or out_valid high after reset");

endmodule

bind erx_dispatch erx_assertions erx_assertions_i (
   .clk, .reset, .out_valid, .out_credit, .rx_credit
);

/* hdl/erx_top.sv */
`timescale 1ns/1ns
module erx_top #(
   parameter int RFAW       = 6,
   parameter int FIFO_DEPTH = 8
) (
   input  logic        clk,
   input  logic        reset,
   // memory interface
   input  logic        mi_en,
   input  logic        mi_we,
   input  logic [14:0] mi_addr,
   input  logic [31:0] mi_din,
   output logic [31:0] mi_dout,
   input  logic [8:0]  gpio_datain,
   output logic        mmu_enable,     // readback only, no MMU here
   // incoming transactions
   input  logic        rx_valid,
   input  logic        rx_write,
   input  logic [31:0] rx_addr,
   input  logic [31:0] rx_data,
   output logic        rx_credit,
   // downstream port
   output logic        out_valid,
   output logic [31:0] out_addr,
   output logic [31:0] out_data,
   input  logic        out_credit
);

   logic [1:0]          remap_mode;
   logic [11:0]         remap_sel;
   logic [11:0]         remap_pattern;
   logic [31:0]         remap_base;
   logic [1:0]          timer_cfg;
   logic [15:0]         rx_status;
   logic                remap_valid;
   logic [31:0]         remap_addr;
   logic [31:0]         remap_data;
   erx_pkg::pkt_class_e chk_class;
   logic                err_misaligned;
   logic                err_read;
   logic                err_timeout;

   // error pulses onto the status vector, upper bits unused
   assign rx_status[erx_pkg::status_misaligned_bit] = err_misaligned;
   assign rx_status[erx_pkg::status_read_bit]       = err_read;
   assign rx_status[erx_pkg::status_timeout_bit]    = err_timeout;
   assign rx_status[15:3]                           = '0;

   erx_cfg #(.RFAW(RFAW)) erx_cfg_i (
      .clk, .reset, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .mmu_enable, .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .timer_cfg, .gpio_datain, .rx_status
   );

   // remap and check run side by side on the raw transaction
   erx_remap erx_remap_i (
      .clk, .reset, .rx_valid, .rx_addr, .rx_data,
      .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .remap_valid, .remap_addr, .remap_data
   );

   erx_check erx_check_i (
      .clk, .reset, .rx_valid, .rx_write, .rx_addr, .chk_class
   );

   erx_dispatch #(.FIFO_DEPTH(FIFO_DEPTH)) erx_dispatch_i (
      .clk, .reset, .remap_valid, .remap_addr, .remap_data, .chk_class,
      .out_credit, .timer_cfg, .out_valid, .out_addr, .out_data, .rx_credit,
      .err_misaligned, .err_read, .err_timeout
   );

endmodule

/* hdl/erx_dispatch.sv */
`timescale 1ns/1ns
module erx_dispatch #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                remap_valid,
   input  logic [31:0]         remap_addr,
   input  logic [31:0]         remap_data,
   input  erx_pkg::pkt_class_e chk_class,
   input  logic                out_credit,     // one credit back per pulse
   input  logic [1:0]          timer_cfg,
   output logic                out_valid,
   output logic [31:0]         out_addr,
   output logic [31:0]         out_data,
   output logic                rx_credit,      // slot freed
   output logic                err_misaligned,
   output logic                err_read,
   output logic                err_timeout
);

   localparam int AW  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW  = $clog2(FIFO_DEPTH + 1);
   localparam int OCW = $clog2(erx_pkg::OUT_CREDITS + 1);

   typedef enum logic [1:0] {st_idle, st_waiting, st_expired} stall_state_e;

   logic [63:0]  fifo_mem [FIFO_DEPTH];   // {addr, data}
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [CW-1:0]  count;
   logic [CW-1:0]  ret_cnt;               // input credits owed
   logic [OCW-1:0] out_cred;
   logic           push;
   logic           drop;
   logic           pop;
   logic           stall;
   logic [10:0]    stall_cnt;
   logic [10:0]    limit;
   stall_state_e   state;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   //####################################################################
   // accept or drop
   //####################################################################
   assign push           = remap_valid && chk_class == erx_pkg::pkt_ok;
   assign drop           = remap_valid && chk_class != erx_pkg::pkt_ok;
   assign err_misaligned = remap_valid && chk_class == erx_pkg::pkt_misaligned;
   assign err_read       = remap_valid && chk_class == erx_pkg::pkt_read;

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= {remap_addr, remap_data};
      end
   end

   // pop straight from the head when a credit is in hand
   assign pop       = (count != '0) && (out_cred != '0);
   assign out_valid = pop;
   assign out_addr  = fifo_mem[rd_ptr][63:32];
   assign out_data  = fifo_mem[rd_ptr][31:0];
   assign rx_credit = (ret_cnt != '0);   // drains owed credits one per cycle

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         ret_cnt  <= '0;
         out_cred <= OCW'(erx_pkg::OUT_CREDITS);
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop)  rd_ptr <= next_ptr(rd_ptr);
         count   <= count + CW'(push) - CW'(pop);
         ret_cnt <= ret_cnt + CW'(pop) + CW'(drop) - CW'(rx_credit);   // up to 2 frees
         case ({pop, out_credit})
            2'b10:   out_cred <= out_cred - OCW'(1);
            2'b01:   out_cred <= out_cred + OCW'(1);
            default: ;   // both or neither, no change
         endcase
      end
   end

   //####################################################################
   // stall timer
   //####################################################################
   assign stall       = (count != '0) && (out_cred == '0);   // stuck on credits
   assign limit       = erx_pkg::timer_limit(timer_cfg);
   assign err_timeout = (state == st_expired);                // single cycle

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         stall_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               stall_cnt <= '0;
               if (stall && limit != '0) state <= st_waiting;
            end
            st_waiting: begin
               if (!stall || limit == '0) begin
                  state <= st_idle;   // credits back or timer off
               end else if (stall_cnt == limit - 11'd1) begin
                  state <= st_expired;
               end else begin
                  stall_cnt <= stall_cnt + 11'd1;
               end
            end
            default: begin   // st_expired, restart count
               stall_cnt <= '0;
               state     <= (stall && limit != '0) ? st_waiting : st_idle;
            end
         endcase
      end
   end

endmodule

/* hdl/erx_check.sv */
`timescale 1ns/1ns
module erx_check (
   input  logic                clk,
   input  logic                reset,
   input  logic                rx_valid,
   input  logic                rx_write,    // 0 = read request
   input  logic [31:0]         rx_addr,
   output erx_pkg::pkt_class_e chk_class    // lines up with remap_valid
);

   erx_pkg::pkt_class_e next_class;

   // reads win over alignment
   always_comb begin
      if (!rx_write) begin
         next_class = erx_pkg::pkt_read;
      end else if (rx_addr[1:0] != 2'b00) begin
         next_class = erx_pkg::pkt_misaligned;   // byte offset set
      end else begin
         next_class = erx_pkg::pkt_ok;
      end
   end

   // hold last verdict between transactions
   always_ff @(posedge clk) begin
      if (reset) begin
         chk_class <= erx_pkg::pkt_ok;
      end else if (rx_valid) begin
         chk_class <= next_class;
      end
   end

endmodule

/* hdl/erx_remap.sv */
`timescale 1ns/1ns
module erx_remap (
   input  logic        clk,
   input  logic        reset,
   input  logic        rx_valid,
   input  logic [31:0] rx_addr,
   input  logic [31:0] rx_data,
   input  logic [1:0]  remap_mode,
   input  logic [11:0] remap_sel,       // 1 = take pattern bit
   input  logic [11:0] remap_pattern,
   input  logic [31:0] remap_base,
   output logic        remap_valid,
   output logic [31:0] remap_addr,
   output logic [31:0] remap_data
);

   logic [31:0] static_addr;
   logic [31:0] next_addr;

   // bit substitution on the top 12 address bits
   assign static_addr = {(rx_addr[31:20] & ~remap_sel) | (remap_pattern & remap_sel),
                         rx_addr[19:0]};

   always_comb begin
      case (remap_mode)
         erx_pkg::remap_static:  next_addr = static_addr;
         erx_pkg::remap_dynamic: next_addr = rx_addr + remap_base;   // wraps at 2^32
         default:                next_addr = rx_addr;   // none and 11
      endcase
   end

   // valid is control, address and data are payload
   always_ff @(posedge clk) begin
      if (reset) begin
         remap_valid <= 1'b0;
      end else begin
         remap_valid <= rx_valid;
      end
   end

   always_ff @(posedge clk) begin
      remap_addr <= next_addr;
      remap_data <= rx_data;
   end

endmodule

/* hdl/erx_cfg.sv */
`timescale 1ns/1ns
module erx_cfg #(
   parameter int RFAW = 6   // register word address field width
) (
   input  logic        clk,
   input  logic        reset,
   // memory interface
   input  logic        mi_en,
   input  logic        mi_we,            // full 32 bit word writes only
   input  logic [14:0] mi_addr,          // byte address
   input  logic [31:0] mi_din,
   output logic [31:0] mi_dout,          // registered readback
   // config outputs
   output logic        mmu_enable,       // stored only
   output logic [1:0]  remap_mode,
   output logic [11:0] remap_sel,
   output logic [11:0] remap_pattern,
   output logic [31:0] remap_base,
   output logic [1:0]  timer_cfg,
   // status inputs
   input  logic [8:0]  gpio_datain,
   input  logic [15:0] rx_status         // error pulses + live bits
);

   logic [31:0]     rx_cfg_reg;
   logic [31:0]     offset_reg;
   logic [8:0]      gpio_reg;
   logic [2:0]      sticky_reg;          // error bits, cleared by reset only
   logic [RFAW-1:0] reg_addr;
   logic            cfg_read;
   logic            cfg_write;

   //####################################################################
   // decode
   //####################################################################
   assign cfg_write = mi_en & mi_we;
   assign cfg_read  = mi_en & ~mi_we;
   assign reg_addr  = mi_addr[RFAW+1:2];   // word address, byte bits dropped

   // rx config word
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_cfg_reg <= '0;
      end else if (cfg_write && reg_addr == RFAW'(erx_pkg::erx_cfg)) begin
         rx_cfg_reg <= mi_din;
      end
   end

   assign mmu_enable    = rx_cfg_reg[1];
   assign remap_mode    = rx_cfg_reg[3:2];
   assign remap_sel     = rx_cfg_reg[15:4];
   assign remap_pattern = rx_cfg_reg[27:16];
   assign timer_cfg     = rx_cfg_reg[29:28];

   // dynamic base, payload only
   always_ff @(posedge clk) begin
      if (cfg_write && reg_addr == RFAW'(erx_pkg::erx_offset)) begin
         offset_reg <= mi_din;
      end
   end

   assign remap_base = offset_reg;

   //####################################################################
   // status capture
   //####################################################################
   always_ff @(posedge clk) begin
      gpio_reg <= gpio_datain;   // free running sample
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         sticky_reg <= '0;
      end else begin
         sticky_reg <= sticky_reg | rx_status[2:0];   // accumulate pulses
      end
   end

   // readback, one cycle behind the request
   always_ff @(posedge clk) begin
      if (cfg_read) begin
         case (reg_addr)
            RFAW'(erx_pkg::erx_cfg):    mi_dout <= rx_cfg_reg;
            RFAW'(erx_pkg::erx_gpio):   mi_dout <= {23'b0, gpio_reg};
            RFAW'(erx_pkg::erx_status): mi_dout <= {16'b0, rx_status[15:3], sticky_reg};
            RFAW'(erx_pkg::erx_offset): mi_dout <= offset_reg;
            default:                    mi_dout <= 32'd0;   // unmapped
         endcase
      end else begin
         mi_dout <= 32'd0;   // idle bus reads zero
      end
   end

endmodule

/* hdl/erx_pkg.sv */
package erx_pkg;

   //####################################################################
   // register file word addresses
   //####################################################################
   typedef enum logic [1:0] {
      erx_cfg    = 2'd0,   // rx config word
      erx_gpio   = 2'd1,   // sampled gpio pins
      erx_status = 2'd2,   // sticky + live status
      erx_offset = 2'd3    // dynamic remap base
   } erx_reg_e;

   // address translation select, 11 falls back to pass-through
   typedef enum logic [1:0] {
      remap_none    = 2'b00,
      remap_static  = 2'b01,
      remap_dynamic = 2'b10
   } remap_mode_e;

   // checker verdict, one per transaction
   typedef enum logic [1:0] {
      pkt_ok         = 2'd0,
      pkt_misaligned = 2'd1,   // write not word aligned
      pkt_read       = 2'd2    // reads not served on this path
   } pkt_class_e;

   typedef enum logic [1:0] {
      timer_off  = 2'd0,
      timer_64   = 2'd1,
      timer_256  = 2'd2,
      timer_1024 = 2'd3
   } timer_cfg_e;

   // rx_status bit map
   localparam int status_misaligned_bit = 0;
   localparam int status_read_bit       = 1;
   localparam int status_timeout_bit    = 2;

   localparam int OUT_CREDITS = 4;   // downstream credits after reset

   // stall limit in cycles, zero means no timeout
   function automatic logic [10:0] timer_limit(input logic [1:0] cfg);
      case (cfg)
         timer_64:   return 11'd64;
         timer_256:  return 11'd256;
         timer_1024: return 11'd1024;
         default:    return 11'd0;
      endcase
   endfunction

endpackage
